/* Bender.yml */
package:
  name: uart

export_include_dirs:
  - hw

sources:
  - files:
      - hw/uart_pkg.sv
      - hw/fifo_if.sv
      - hw/fifo.sv
      - hw/baud_gen.sv
      - hw/uart_rx.sv
      - hw/uart_tx.sv
      - hw/uart_top.sv
  - target: test
    files:
      - tb/tb_uart.sv

/* build.f */
+incdir+hw
hw/uart_pkg.sv
hw/fifo_if.sv
hw/fifo.sv
hw/baud_gen.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/uart_top.sv
tb/tb_uart.sv

/* hw/baud_gen.sv */
`timescale 1ns/1ns
`include "uart_macros.svh"

// Oversampling strobe, one clock wide, every UART_DVSR clocks
module baud_gen (
    input  logic clk,
    input  logic rst,
    output logic tick
);

    // At least one bit even for a divisor of 1
    localparam int CNT_BITS = (`UART_DVSR > 1) ? $clog2(`UART_DVSR) : 1;

    localparam logic [CNT_BITS-1:0] LAST_CNT = CNT_BITS'(`UART_DVSR - 1);

    logic [CNT_BITS-1:0] cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (cnt == LAST_CNT) begin
            cnt <= '0;  // Wrap on terminal count
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // Terminal count doubles as the tick
    assign tick = (cnt == LAST_CNT);

endmodule

/* hw/fifo.sv */
`timescale 1ns/1ns
`include "uart_macros.svh"

module fifo import uart_pkg::*; #(
    parameter int ADDR_BITS = `FIFO_ADDR_BITS
) (
    input  logic clk,
    input  logic rst,
    fifo_if.fifo bus
);

    localparam int DEPTH = 2 ** ADDR_BITS;

    typedef logic [ADDR_BITS-1:0] addr_t;

    uart_byte_t mem [DEPTH];    // Register array storage

    addr_t wr_ptr, wr_ptr_next;
    addr_t rd_ptr, rd_ptr_next;
    addr_t wr_ptr_inc, rd_ptr_inc;
    logic  empty_q, empty_next;
    logic  full_q, full_next;
    logic  wr_ok;   // Write accepted this cycle
    logic  rd_ok;   // Read accepted this cycle

    // Each strobe checked against its own flag only
    assign wr_ok = bus.wr & ~full_q;
    assign rd_ok = bus.rd & ~empty_q;

    assign wr_ptr_inc = wr_ptr + 1'b1;
    assign rd_ptr_inc = rd_ptr + 1'b1;

    //////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= bus.wr_data;
        end
    end

    assign bus.rd_data = mem[rd_ptr];   // Valid while not empty

    //////////////////////////////////////////////////
    // Pointers and levels
    //////////////////////////////////////////////////

    always_comb begin
        wr_ptr_next = wr_ptr;   // Hold by default
        rd_ptr_next = rd_ptr;
        empty_next  = empty_q;
        full_next   = full_q;
        case ({wr_ok, rd_ok})
            2'b01: begin    // Pop only
                rd_ptr_next = rd_ptr_inc;
                full_next   = 1'b0;
                if (rd_ptr_inc == wr_ptr) begin
                    empty_next = 1'b1;  // Caught up with writer
                end
            end
            2'b10: begin    // Push only
                wr_ptr_next = wr_ptr_inc;
                empty_next  = 1'b0;
                if (wr_ptr_inc == rd_ptr) begin
                    full_next = 1'b1;   // Wrapped onto reader
                end
            end
            2'b11: begin
                // Count unchanged, both flags stay
                wr_ptr_next = wr_ptr_inc;
                rd_ptr_next = rd_ptr_inc;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            empty_q <= 1'b1;
            full_q  <= 1'b0;
        end else begin
            wr_ptr  <= wr_ptr_next;
            rd_ptr  <= rd_ptr_next;
            empty_q <= empty_next;
            full_q  <= full_next;
        end
    end

    assign bus.empty = empty_q;
    assign bus.full  = full_q;

endmodule

/* hw/fifo_if.sv */
`timescale 1ns/1ns

// One direction of byte buffering
interface fifo_if import uart_pkg::*; ();

    logic       wr;         // Write strobe
    uart_byte_t wr_data;
    logic       rd;         // Read strobe, pops oldest entry
    uart_byte_t rd_data;    // Oldest entry, combinational
    logic       empty;
    logic       full;

    // Writing side
    modport producer (
        output wr,
        output wr_data,
        input  full
    );

    // Reading side
    modport consumer (
        output rd,
        input  rd_data,
        input  empty
    );

    // Storage itself
    modport fifo (
        input  wr,
        input  wr_data,
        input  rd,
        output rd_data,
        output empty,
        output full
    );

endinterface

/* hw/uart_macros.svh */
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

//////////////////////////////////////////////////
// Baud timing
//////////////////////////////////////////////////

// Clock cycles per oversampling tick
// Kept small so a frame is 320 clocks in simulation
`define UART_DVSR 2

// Oversampling ticks per serial bit
`define UART_OVS 16

//////////////////////////////////////////////////
// Buffering
//////////////////////////////////////////////////

`define FIFO_ADDR_BITS 4    // 16 entries per direction

`endif

/* hw/uart_pkg.sv */
package uart_pkg;

    //////////////////////////////////////////////////
    // Data and counter widths
    //////////////////////////////////////////////////

    typedef logic [7:0] uart_byte_t;    // One frame payload, 8N1
    typedef logic [3:0] tick_cnt_t;     // Counts oversampling ticks within a bit

    //////////////////////////////////////////////////
    // FSM encodings
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {
        RX_IDLE,    // Line high, waiting for falling edge
        RX_START,   // Heading to middle of start bit
        RX_DATA,    // Sampling 8 data bits
        RX_STOP     // Checking stop bit
    } rx_state_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

endpackage

/* hw/uart_rx.sv */
`timescale 1ns/1ns
`include "uart_macros.svh"

module uart_rx import uart_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     rx,
    input  logic     tick,
    fifo_if.producer rx_fifo
);

    localparam tick_cnt_t MID_TICK  = tick_cnt_t'(`UART_OVS / 2 - 1);
    localparam tick_cnt_t LAST_TICK = tick_cnt_t'(`UART_OVS - 1);

    logic [1:0] rx_sync;    // Metastability guard
    logic       rx_s;       // Synchronized line
    rx_state_t  state;
    tick_cnt_t  tick_cnt;
    logic [2:0] bit_cnt;
    uart_byte_t shift_reg;
    logic       wr_pulse;
    logic       bit_done;   // Full bit period elapsed on this tick

    assign rx_s     = rx_sync[1];
    assign bit_done = tick && (tick_cnt == LAST_TICK);

    //////////////////////////////////////////////////
    // Input synchronizer
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_sync <= 2'b11;   // Idle line is high
        end else begin
            rx_sync <= {rx_sync[0], rx};
        end
    end

    //////////////////////////////////////////////////
    // Frame FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= RX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            wr_pulse <= 1'b0;
        end else begin
            wr_pulse <= 1'b0;   // Strobe lasts one clock
            case (state)
                RX_IDLE: begin
                    if (!rx_s) begin
                        state    <= RX_START;
                        tick_cnt <= '0;
                    end
                end
                RX_START: begin
                    if (tick) begin
                        if (tick_cnt == MID_TICK) begin
                            tick_cnt <= '0;
                            bit_cnt  <= '0;
                            // Line back high here means a glitch, not a start bit
                            state    <= rx_s ? RX_IDLE : RX_DATA;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                RX_DATA: begin
                    if (bit_done) begin
                        tick_cnt <= '0;
                        if (bit_cnt == 3'd7) begin
                            state <= RX_STOP;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end else if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (bit_done) begin
                        tick_cnt <= '0;
                        state    <= RX_IDLE;
                        wr_pulse <= rx_s;   // Bad stop bit drops the byte
                    end else if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // Mid-bit sample, LSB arrives first
    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_done) begin
            shift_reg <= {rx_s, shift_reg[7:1]};
        end
    end

    // FIFO drops the byte itself when full
    assign rx_fifo.wr      = wr_pulse;
    assign rx_fifo.wr_data = shift_reg;

endmodule

/* hw/uart_top.sv */
`timescale 1ns/1ns

module uart_top import uart_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       rx,          // Serial in
    output logic       tx,          // Serial out
    input  logic       wr_uart,     // Host write into tx FIFO
    input  uart_byte_t w_data,
    input  logic       rd_uart,     // Host pop from rx FIFO
    output uart_byte_t r_data,
    output logic       rx_empty,
    output logic       tx_full
);

    logic tick;     // Shared oversampling strobe

    fifo_if tx_fifo_bus ();
    fifo_if rx_fifo_bus ();

    //////////////////////////////////////////////////
    // Host side of the two buffers
    //////////////////////////////////////////////////

    assign tx_fifo_bus.wr      = wr_uart;
    assign tx_fifo_bus.wr_data = w_data;
    assign tx_full             = tx_fifo_bus.full;

    assign rx_fifo_bus.rd = rd_uart;
    assign r_data         = rx_fifo_bus.rd_data;
    assign rx_empty       = rx_fifo_bus.empty;

    //////////////////////////////////////////////////
    // Blocks
    //////////////////////////////////////////////////

    baud_gen u_baud (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    // Host to line
    fifo u_tx_fifo (
        .clk (clk),
        .rst (rst),
        .bus (tx_fifo_bus.fifo)
    );

    // Line to host
    fifo u_rx_fifo (
        .clk (clk),
        .rst (rst),
        .bus (rx_fifo_bus.fifo)
    );

    uart_rx u_rx (
        .clk     (clk),
        .rst     (rst),
        .rx      (rx),
        .tick    (tick),
        .rx_fifo (rx_fifo_bus.producer)
    );

    uart_tx u_tx (
        .clk     (clk),
        .rst     (rst),
        .tick    (tick),
        .tx      (tx),
        .tx_fifo (tx_fifo_bus.consumer)
    );

endmodule

/* hw/uart_tx.sv */
`timescale 1ns/1ns
`include "uart_macros.svh"

module uart_tx import uart_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     tick,
    output logic     tx,
    fifo_if.consumer tx_fifo
);

    localparam tick_cnt_t LAST_TICK = tick_cnt_t'(`UART_OVS - 1);

    tx_state_t  state;
    tick_cnt_t  tick_cnt;
    logic [2:0] bit_cnt;
    uart_byte_t shift_reg;
    logic       pop;        // Take next byte from FIFO
    logic       bit_done;
    logic       tx_next;    // Line level for current state

    assign pop      = (state == TX_IDLE) && !tx_fifo.empty;
    assign bit_done = tick && (tick_cnt == LAST_TICK);

    assign tx_fifo.rd = pop;    // Byte leaves FIFO as frame starts

    //////////////////////////////////////////////////
    // Frame FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= TX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (pop) begin
                        state    <= TX_START;
                        tick_cnt <= '0;
                        bit_cnt  <= '0;
                    end
                end
                TX_START: begin
                    if (bit_done) begin
                        tick_cnt <= '0;
                        state    <= TX_DATA;
                    end else if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                TX_DATA: begin
                    if (bit_done) begin
                        tick_cnt <= '0;
                        if (bit_cnt == 3'd7) begin
                            state <= TX_STOP;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end else if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                TX_STOP: begin
                    if (bit_done) begin
                        tick_cnt <= '0;
                        state    <= TX_IDLE;    // Next byte may pop right away
                    end else if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Payload, loaded on pop, shifted right per data bit
    always_ff @(posedge clk) begin
        if (pop) begin
            shift_reg <= tx_fifo.rd_data;
        end else if (state == TX_DATA && bit_done) begin
            shift_reg <= {1'b0, shift_reg[7:1]};
        end
    end

    always_comb begin
        case (state)
            TX_START: tx_next = 1'b0;
            TX_DATA:  tx_next = shift_reg[0];
            default:  tx_next = 1'b1;   // Idle and stop are high
        endcase
    end

    // Line changes on tick boundaries only, glitch free
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx <= 1'b1;
        end else if (tick) begin
            tx <= tx_next;
        end
    end

endmodule

/* tb/tb_uart.sv */
`timescale 1ns/1ns
`include "uart_macros.svh"

module tb_uart import uart_pkg::*; ();

    localparam int BIT_CLKS   = `UART_DVSR * `UART_OVS;    // Clocks per serial bit
    localparam int FRAME_CLKS = BIT_CLKS * 10;             // Start, 8 data, stop
    localparam int DEPTH      = 2 ** `FIFO_ADDR_BITS;

    logic       clk;
    logic       rst;
    logic       rx;
    logic       tx;
    logic       wr_uart;
    uart_byte_t w_data;
    logic       rd_uart;
    uart_byte_t r_data;
    logic       rx_empty;
    logic       tx_full;

    integer seed;
    int     errors;
    int     timeouts;
    int     checks;

    uart_top u_dut (
        .clk      (clk),
        .rst      (rst),
        .rx       (rx),
        .tx       (tx),
        .wr_uart  (wr_uart),
        .w_data   (w_data),
        .rd_uart  (rd_uart),
        .r_data   (r_data),
        .rx_empty (rx_empty),
        .tx_full  (tx_full)
    );

    always #4 clk = ~clk;   // 8 ns period

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error: %s expected 0x%0h actual 0x%0h", name, exp, act);
        end
    endtask

    // One host write with the strobe high for one clock
    task automatic write_byte(input uart_byte_t data);
        @(posedge clk);
        wr_uart <= 1'b1;
        w_data  <= data;
        @(posedge clk);
        wr_uart <= 1'b0;
    endtask

    // Wait for rx data, compare, then pop it
    task automatic read_byte(input string name, input uart_byte_t exp);
        int n;
        n = 0;
        @(negedge clk);
        while (rx_empty && n < 2 * FRAME_CLKS) begin
            @(negedge clk);
            n++;
        end
        if (rx_empty) begin
            timeouts++;
            $display("Timeout: no byte reached the receive FIFO in %s", name);
        end else begin
            check(name, exp, r_data);
            @(posedge clk);
            rd_uart <= 1'b1;
            @(posedge clk);
            rd_uart <= 1'b0;   // Pop taken at this edge
        end
    endtask

    // 8N1 frame on rx with LSB first
    task automatic send_frame(input uart_byte_t data);
        logic [9:0] bits;
        bits = {1'b1, data, 1'b0};  // Stop, payload, start
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rx <= bits[i];
            repeat (BIT_CLKS - 1) @(posedge clk);
        end
    endtask

    // Catch one frame on tx by sampling mid-bit
    task automatic get_frame(input string name, output uart_byte_t data);
        int n;
        n    = 0;
        data = 'x;
        @(negedge clk);
        while (tx && n < 4 * FRAME_CLKS) begin
            @(negedge clk);
            n++;
        end
        if (tx) begin
            timeouts++;
            $display("Timeout: no start bit appeared on tx in %s", name);
        end else begin
            repeat (BIT_CLKS / 2) @(negedge clk);   // Middle of start bit
            check({name, " start bit"}, 0, tx);
            for (int i = 0; i < 8; i++) begin
                repeat (BIT_CLKS) @(negedge clk);
                data[i] = tx;
            end
            repeat (BIT_CLKS) @(negedge clk);
            check({name, " stop bit"}, 1, tx);
        end
    endtask

    // Line must stay high with no stray frame
    task automatic line_idle(input string name, input int clks);
        int lows;
        lows = 0;
        repeat (clks) begin
            @(negedge clk);
            if (tx !== 1'b1) lows++;
        end
        check({name, " idle line"}, 0, lows);
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic reset_state();
        @(negedge clk);
        check("reset tx", 1, tx);
        check("reset rx_empty", 1, rx_empty);
        check("reset tx_full", 0, tx_full);
    endtask

    task automatic single_transmit();
        uart_byte_t b;
        uart_byte_t got;
        b = uart_byte_t'($random(seed));
        write_byte(b);
        get_frame("single_tx", got);
        check("single_tx", b, got);
    endtask

    task automatic single_receive();
        uart_byte_t b;
        b = uart_byte_t'($random(seed));
        send_frame(b);
        read_byte("single_rx", b);
        @(negedge clk);
        check("single_rx empty", 1, rx_empty);
    endtask

    // Back-to-back writes one per clock past the depth
    task automatic transmit_burst();
        uart_byte_t exp_q[$];
        uart_byte_t b;
        uart_byte_t first;
        uart_byte_t got;
        int         drops;
        drops = 0;
        fork
            begin
                for (int i = 0; i < DEPTH + 2; i++) begin
                    b = uart_byte_t'($random(seed));
                    @(posedge clk);
                    wr_uart <= 1'b1;
                    w_data  <= b;
                    @(negedge clk);
                    if (tx_full) drops++;   // Full at the next edge drops this write
                    else exp_q.push_back(b);
                end
                @(posedge clk);
                wr_uart <= 1'b0;
            end
            get_frame("tx_burst", first);   // First frame starts during the burst
        join
        // First byte popped at once, so depth plus one accepted
        check("tx_burst accepted", DEPTH + 1, exp_q.size());
        check("tx_burst dropped", 1, drops);
        check("tx_burst", exp_q.pop_front(), first);
        while (exp_q.size() > 0) begin
            get_frame("tx_burst", got);
            check("tx_burst", exp_q.pop_front(), got);
        end
        line_idle("tx_burst", FRAME_CLKS);
        check("tx_burst tx_full", 0, tx_full);
    endtask

    // No reads until all frames are in
    task automatic receive_overflow();
        uart_byte_t exp_q[$];
        uart_byte_t b;
        for (int i = 0; i < DEPTH + 1; i++) begin
            b = uart_byte_t'($random(seed));
            send_frame(b);
            if (exp_q.size() < DEPTH) exp_q.push_back(b);   // Full FIFO drops it
        end
        while (exp_q.size() > 0) begin
            read_byte("rx_overflow", exp_q.pop_front());
        end
        @(negedge clk);
        check("rx_overflow empty", 1, rx_empty);
    endtask

    task automatic full_duplex();
        uart_byte_t tb_byte;
        uart_byte_t rb;
        uart_byte_t got;
        tb_byte = uart_byte_t'($random(seed));
        rb      = uart_byte_t'($random(seed));
        fork
            send_frame(rb);
            begin
                write_byte(tb_byte);
                get_frame("duplex_tx", got);
            end
        join
        check("duplex_tx", tb_byte, got);
        read_byte("duplex_rx", rb);
    endtask

    //////////////////////////////////////////////////
    // Sequence
    //////////////////////////////////////////////////

    initial begin
        seed     = 14;
        errors   = 0;
        timeouts = 0;
        checks   = 0;
        clk      = 1'b0;
        rst      = 1'b1;
        rx       = 1'b1;    // Idle line
        wr_uart  = 1'b0;
        w_data   = '0;
        rd_uart  = 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        reset_state();
        single_transmit();
        single_receive();
        transmit_burst();
        receive_overflow();
        full_duplex();

        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
